/* vlog.f */
+incdir+.
oramCryptoPkg.sv
creditFifo.sv
seedGen.sv
keystreamCore.sv
maskApply.sv
bucketCrypt.sv
tb_bucketCrypt.sv

/* Bender.yml */
package:
  name: bucket_crypt

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - oramCryptoPkg.sv
      - creditFifo.sv
      - seedGen.sv
      - keystreamCore.sv
      - maskApply.sv
      - bucketCrypt.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_bucketCrypt.sv

/* tb_bucketCrypt.sv */
/*
 * Directed testbench for the bucket encryption top,
 * reference keystream model, credit book and value check
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module tb_bucketCrypt;

	localparam int BlkW = `ORAM_BLK_W;
	localparam int Chunks = `ORAM_BKT_CHUNKS;
	localparam int Timeout = 200;

	logic Clock;
	logic rstN;
	logic cmdValid;
	oramCryptoPkg::cmdT cmd;
	logic cmdCredit;
	logic dataInValid;
	logic [BlkW-1:0] dataIn;
	logic dataInReady;
	logic dataOutValid;
	logic [BlkW-1:0] dataOut;
	logic dataOutReady;

	// Host side credit book
	int hostCredits;

	// Stimulus and expected beats of one run
	oramCryptoPkg::cmdT cmdList [$];
	logic [BlkW-1:0] beatData [$];
	logic [BlkW-1:0] beatExp [$];
	int stallLen [$];

	bucketCrypt i_dut (
		.Clock(Clock),
		.rstN(rstN),
		.cmdValid(cmdValid),
		.cmd(cmd),
		.cmdCredit(cmdCredit),
		.dataInValid(dataInValid),
		.dataIn(dataIn),
		.dataInReady(dataInReady),
		.dataOutValid(dataOutValid),
		.dataOut(dataOut),
		.dataOutReady(dataOutReady)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	// Each pulse returns one spent credit
	always @(posedge Clock) begin
		if (rstN && cmdCredit) begin
			if (hostCredits >= `ORAM_CMD_DEPTH)
				failRun("cmdCredit pulsed with no command outstanding");
			hostCredits++;
		end
	end

	// ----------------------------------------
	// Checks and reference model
	// ----------------------------------------

	task automatic failRun(input string what);
		$display("failure at time %0t: %s", $time, what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [BlkW-1:0] got,
			input logic [BlkW-1:0] exp);
		if (got !== exp) begin
			$display("error: time %0t signal %s expected %h got %h", $time, name, exp, got);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Key XOR, rotate left, add scaled constant, per round
	task automatic modelMask(input logic [BlkW-1:0] seedVal, output logic [BlkW-1:0] m);
		logic [BlkW-1:0] keys [4];
		logic [BlkW-1:0] x;
		keys[0] = `ORAM_KEY0;
		keys[1] = `ORAM_KEY1;
		keys[2] = `ORAM_KEY2;
		keys[3] = `ORAM_KEY3;
		x = seedVal;
		for (int r = 0; r < `ORAM_ROUNDS; r++) begin
			x = x ^ keys[r];
			x = (x << `ORAM_ROT) | (x >> (BlkW - `ORAM_ROT));
			x = x + BlkW'(`ORAM_RCONST * (r + 1));
		end
		m = x;
	endtask

	// Seed is zero pad, iv, bucket ID, chunk index
	task automatic planBucket(input oramCryptoPkg::cmdT c, input bit zeroData);
		logic [BlkW-1:0] seedVal;
		logic [BlkW-1:0] m;
		logic [BlkW-1:0] d;
		for (int k = 0; k < Chunks; k++) begin
			seedVal = BlkW'({c.iv, c.bucketId, `ORAM_CID_W'(k)});
			modelMask(seedVal, m);
			d = zeroData ? '0 : {$urandom, $urandom};
			beatData.push_back(d);
			beatExp.push_back(d ^ m);
		end
	endtask

	// ----------------------------------------
	// Bus tasks
	// ----------------------------------------

	// Push only with a credit in hand
	task automatic sendCmd(input oramCryptoPkg::cmdT c);
		int waitCycles;
		waitCycles = 0;
		@(negedge Clock);
		while (hostCredits == 0) begin
			cmdValid = 1'b0;
			if (waitCycles == Timeout)
				failRun("no command credit came back from the DUT");
			waitCycles++;
			@(negedge Clock);
		end
		cmdValid = 1'b1;
		cmd = c;
		hostCredits--;
	endtask

	// Valid stays up, caller drops it after the last beat
	task automatic sendBeat(input logic [BlkW-1:0] data);
		int waitCycles;
		waitCycles = 0;
		@(negedge Clock);
		dataInValid = 1'b1;
		dataIn = data;
		@(posedge Clock);
		while (!dataInReady) begin
			if (waitCycles == Timeout)
				failRun("data beat was never accepted by the DUT");
			waitCycles++;
			@(posedge Clock);
		end
	endtask

	// Hold ready low for the stall, then take one beat
	task automatic recvBeat(input int stall, output logic [BlkW-1:0] got);
		int waitCycles;
		waitCycles = 0;
		repeat (stall) begin
			@(negedge Clock);
			dataOutReady = 1'b0;
		end
		@(negedge Clock);
		dataOutReady = 1'b1;
		@(posedge Clock);
		while (!dataOutValid) begin
			if (waitCycles == Timeout)
				failRun("no output beat came from the DUT");
			waitCycles++;
			@(posedge Clock);
		end
		got = dataOut;
	endtask

	task automatic waitCredits();
		int waitCycles;
		waitCycles = 0;
		@(negedge Clock);
		while (hostCredits != `ORAM_CMD_DEPTH) begin
			if (waitCycles == Timeout)
				failRun("command credits did not all come back");
			waitCycles++;
			@(negedge Clock);
		end
	endtask

	// Commands, data and output run side by side
	task automatic runTraffic(input int nCmds, input bit zeroData, input int maxStall);
		oramCryptoPkg::cmdT c;
		cmdList.delete();
		beatData.delete();
		beatExp.delete();
		stallLen.delete();
		for (int i = 0; i < nCmds; i++) begin
			c.iv = $urandom;
			c.bucketId = $urandom;
			cmdList.push_back(c);
			planBucket(c, zeroData);
		end
		for (int i = 0; i < nCmds * Chunks; i++)
			stallLen.push_back((maxStall == 0) ? 0 : $urandom_range(maxStall));
		fork
			begin
				foreach (cmdList[i])
					sendCmd(cmdList[i]);
				@(negedge Clock);
				cmdValid = 1'b0;
			end
			begin
				foreach (beatData[i])
					sendBeat(beatData[i]);
				@(negedge Clock);
				dataInValid = 1'b0;
			end
			begin
				logic [BlkW-1:0] got;
				foreach (beatExp[i]) begin
					recvBeat(stallLen[i], got);
					checkValue("dataOut", got, beatExp[i]);
				end
			end
		join
		// One credit per command, extras are caught on the pulse
		waitCredits();
		// Nothing extra left in the pipe
		checkValue("dataOutValid", dataOutValid, 1'b0);
		checkValue("dataInReady", dataInReady, 1'b0);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------

	initial begin
		void'($urandom(32'h37877fbc));
		rstN = 1'b0;
		cmdValid = 1'b0;
		cmd = '0;
		dataInValid = 1'b0;
		dataIn = '0;
		dataOutReady = 1'b1;
		hostCredits = `ORAM_CMD_DEPTH;
		repeat (2) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;

		// Quiet after reset, no mask so no ready
		checkValue("dataOutValid", dataOutValid, 1'b0);
		checkValue("cmdCredit", cmdCredit, 1'b0);
		repeat (10) begin
			@(posedge Clock);
			checkValue("dataInReady", dataInReady, 1'b0);
		end

		// Zero data shows the raw masks
		runTraffic(1, 1'b1, 0);
		runTraffic(1, 1'b0, 0);
		// Every initial credit in one go
		runTraffic(`ORAM_CMD_DEPTH, 1'b0, 0);
		// Output stalls, host runs dry on credits
		runTraffic(6, 1'b0, 5);

		$display("Test passed");
		$finish;
	end

endmodule

/* bucketCrypt.sv */
/*
 * Bucket encryption top, chains command queue, seed generation,
 * keystream pipeline, mask queue and mask application
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module bucketCrypt (
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   cmdValid,
	input  oramCryptoPkg::cmdT     cmd,
	output logic                   cmdCredit,
	input  logic                   dataInValid,
	input  logic [`ORAM_BLK_W-1:0] dataIn,
	output logic                   dataInReady,
	output logic                   dataOutValid,
	output logic [`ORAM_BLK_W-1:0] dataOut,
	input  logic                   dataOutReady
);

	// ----------------------------------------
	// Stage wires
	// ----------------------------------------

	oramCryptoPkg::cmdT  cmdHead;
	oramCryptoPkg::seedT seed;
	oramCryptoPkg::maskT mask;
	oramCryptoPkg::maskT maskHead;
	logic cmdHeadValid;
	logic cmdPop;
	logic seedValid;
	logic maskValid;
	logic maskHeadValid;
	logic maskPop;
	logic maskCredit;

	// Host commands, credits back to the host
	creditFifo #(
		.payloadT(oramCryptoPkg::cmdT),
		.depth(`ORAM_CMD_DEPTH)
	) cmdQueue (
		.Clock(Clock),
		.rstN(rstN),
		.push(cmdValid),
		.pushData(cmd),
		.pop(cmdPop),
		.popValid(cmdHeadValid),
		.popData(cmdHead),
		.creditReturn(cmdCredit)
	);

	// One seed per chunk
	seedGen seedGenerator (
		.Clock(Clock),
		.rstN(rstN),
		.cmdValid(cmdHeadValid),
		.cmd(cmdHead),
		.cmdPop(cmdPop),
		.creditReturn(maskCredit),
		.seedValid(seedValid),
		.seed(seed)
	);

	// Non-stalling cipher
	keystreamCore keystream (
		.Clock(Clock),
		.rstN(rstN),
		.seedValid(seedValid),
		.seed(seed),
		.maskValid(maskValid),
		.mask(mask)
	);

	// Masks wait here for data, credits back to seedGen
	creditFifo #(
		.payloadT(oramCryptoPkg::maskT),
		.depth(`ORAM_MASK_DEPTH)
	) maskQueue (
		.Clock(Clock),
		.rstN(rstN),
		.push(maskValid),
		.pushData(mask),
		.pop(maskPop),
		.popValid(maskHeadValid),
		.popData(maskHead),
		.creditReturn(maskCredit)
	);

	// XOR onto the bucket data stream
	maskApply maskXor (
		.Clock(Clock),
		.rstN(rstN),
		.maskValid(maskHeadValid),
		.mask(maskHead),
		.maskPop(maskPop),
		.dataInValid(dataInValid),
		.dataIn(dataIn),
		.dataInReady(dataInReady),
		.dataOutValid(dataOutValid),
		.dataOut(dataOut),
		.dataOutReady(dataOutReady)
	);

endmodule

/* maskApply.sv */
/*
 * Mask application, pairs the head mask with a data beat
 * and registers the XOR result for the output handshake
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module maskApply (
	input  logic                   Clock,
	input  logic                   rstN,
	input  logic                   maskValid,
	input  oramCryptoPkg::maskT    mask,
	output logic                   maskPop,
	input  logic                   dataInValid,
	input  logic [`ORAM_BLK_W-1:0] dataIn,
	output logic                   dataInReady,
	output logic                   dataOutValid,
	output logic [`ORAM_BLK_W-1:0] dataOut,
	input  logic                   dataOutReady
);

	logic outFree;
	logic fire;

	// ----------------------------------------
	// Join
	// ----------------------------------------

	// Output register empty or being drained this cycle
	assign outFree = !dataOutValid || dataOutReady;
	// Beat accepted only when a mask is waiting
	assign dataInReady = maskValid && outFree;
	assign fire = dataInReady && dataInValid;
	// Mask leaves together with its beat
	assign maskPop = fire;

	// ----------------------------------------
	// Output register
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN)
			dataOutValid <= 1'b0;
		else if (fire)
			dataOutValid <= 1'b1;
		else if (dataOutReady)
			dataOutValid <= 1'b0;
	end

	// XOR result holds while stalled
	always_ff @(posedge Clock) begin
		if (fire)
			dataOut <= dataIn ^ mask.mask;
	end

endmodule

/* keystreamCore.sv */
/*
 * Keystream cipher, fixed-latency pipeline of
 * add-rotate-XOR rounds turning seeds into masks
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module keystreamCore (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                seedValid,
	input  oramCryptoPkg::seedT seed,
	output logic                maskValid,
	output oramCryptoPkg::maskT mask
);

	localparam int BlkW = `ORAM_BLK_W;
	localparam int Rounds = `ORAM_ROUNDS;
	localparam int Rot = `ORAM_ROT;

	// Key table, indexed by round
	localparam logic [BlkW-1:0] roundKeys [4] = '{
		`ORAM_KEY0,
		`ORAM_KEY1,
		`ORAM_KEY2,
		`ORAM_KEY3
	};

	// ----------------------------------------
	// Round function
	// ----------------------------------------

	// Key XOR, rotate left, then add constant
	function automatic logic [BlkW-1:0] cipherRound(
		input logic [BlkW-1:0] x,
		input logic [BlkW-1:0] key,
		input logic [BlkW-1:0] addend
	);
		logic [BlkW-1:0] t;
		t = x ^ key;
		t = (t << Rot) | (t >> (BlkW - Rot));
		// Wraps modulo 2^64
		return t + addend;
	endfunction

	// ----------------------------------------
	// Pipeline stages
	// ----------------------------------------

	logic [BlkW-1:0] stageIn [Rounds];
	logic [BlkW-1:0] blk [Rounds];
	logic [Rounds-1:0] stageValid;

	for (genvar r = 0; r < Rounds; r++) begin : gRound
		localparam logic [BlkW-1:0] key = roundKeys[r % 4];
		// Round constant scaled by round number
		localparam logic [BlkW-1:0] addend = `ORAM_RCONST * BlkW'(r + 1);

		// Stage 0 takes the seed, later ones the previous round
		if (r == 0) begin : gFirst
			assign stageIn[r] = seed;
		end else begin : gNext
			assign stageIn[r] = blk[r-1];
		end

		// Valid bit, cleared by reset
		always_ff @(posedge Clock) begin
			if (!rstN)
				stageValid[r] <= 1'b0;
			else if (r == 0)
				stageValid[r] <= seedValid;
			else
				stageValid[r] <= stageValid[r-1];
		end

		// Block register runs every cycle
		always_ff @(posedge Clock) begin
			blk[r] <= cipherRound(stageIn[r], key, addend);
		end
	end

	// Last round output is the mask
	assign maskValid = stageValid[Rounds-1];
	assign mask.mask = blk[Rounds-1];

endmodule

/* seedGen.sv */
/*
 * Seed generation, walks the chunks of each bucket command
 * and issues one seed per cycle against mask queue credits
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module seedGen (
	input  logic                Clock,
	input  logic                rstN,
	input  logic                cmdValid,
	input  oramCryptoPkg::cmdT  cmd,
	output logic                cmdPop,
	input  logic                creditReturn,
	output logic                seedValid,
	output oramCryptoPkg::seedT seed
);

	localparam int CidW = `ORAM_CID_W;
	localparam int CreditW = $clog2(`ORAM_MASK_DEPTH + 1);
	localparam logic [CidW-1:0] lastChunk = CidW'(`ORAM_BKT_CHUNKS - 1);

	// ----------------------------------------
	// State
	// ----------------------------------------

	oramCryptoPkg::cmdT cmdReg;
	logic active;
	logic [CidW-1:0] chunkIdx;
	logic [CreditW-1:0] credits;
	logic issue;
	logic lastIssue;

	// Seed goes out only with a credit in hand
	assign issue = active && (credits != '0);
	assign lastIssue = issue && (chunkIdx == lastChunk);
	// Take the next command when idle or on the last chunk
	assign cmdPop = cmdValid && (!active || lastIssue);

	// Latched command fields
	always_ff @(posedge Clock) begin
		if (cmdPop)
			cmdReg <= cmd;
	end

	// ----------------------------------------
	// Chunk walk and credits
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			active <= 1'b0;
			chunkIdx <= '0;
			credits <= CreditW'(`ORAM_MASK_DEPTH);
			seedValid <= 1'b0;
		end else begin
			if (cmdPop) begin
				active <= 1'b1;
				chunkIdx <= '0;
			end else if (lastIssue) begin
				active <= 1'b0;
			end else if (issue) begin
				chunkIdx <= chunkIdx + 1'b1;
			end
			// One spent per seed, one back per popped mask
			case ({issue, creditReturn})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			seedValid <= issue;
		end
	end

	// Seed built from the latched command and chunk index
	always_ff @(posedge Clock) begin
		if (issue) begin
			seed.pad <= '0;
			seed.iv <= cmdReg.iv;
			seed.bucketId <= cmdReg.bucketId;
			seed.chunkId <= chunkIdx;
		end
	end

	// Mask queue never hands back more than it holds
	assert property (@(posedge Clock) disable iff (!rstN)
		credits <= CreditW'(`ORAM_MASK_DEPTH))
		else $error("seedGen: credit overflow");

endmodule

/* creditFifo.sv */
/*
 * Circular buffer queue with a payload type parameter,
 * returns one credit to the producer per popped entry
 */
`timescale 1ns/1ns
`include "oramCrypto_params.svh"

module creditFifo #(
	parameter type payloadT = logic [`ORAM_BLK_W-1:0],
	parameter int depth = `ORAM_CMD_DEPTH
) (
	input  logic    Clock,
	input  logic    rstN,
	input  logic    push,
	input  payloadT pushData,
	input  logic    pop,
	output logic    popValid,
	output payloadT popData,
	output logic    creditReturn
);

	// ----------------------------------------
	// Storage and pointers
	// ----------------------------------------

	localparam int PtrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int CntW = $clog2(depth + 1);
	localparam logic [PtrW-1:0] lastPtr = PtrW'(depth - 1);

	payloadT mem [depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;
	logic full;

	assign full = (count == CntW'(depth));
	assign popValid = (count != '0);
	// Head entry read straight from the array
	assign popData = mem[rdPtr];

	// Entry write
	always_ff @(posedge Clock) begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// ----------------------------------------
	// Control
	// ----------------------------------------

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			// Wrap at depth, not at a power of two
			if (push)
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Credit goes back one cycle after the pop
			creditReturn <= pop;
		end
	end

	// Producer pushed without a credit
	assert property (@(posedge Clock) disable iff (!rstN) push |-> !full)
		else $error("creditFifo: push while full");

	// Consumer popped an empty queue
	assert property (@(posedge Clock) disable iff (!rstN) pop |-> popValid)
		else $error("creditFifo: pop while empty");

endmodule

/* oramCryptoPkg.sv */
/*
 * Shared struct types for the bucket encryption unit:
 * host command, cipher seed and keystream mask
 */
`include "oramCrypto_params.svh"

package oramCryptoPkg;

	// ----------------------------------------
	// Derived widths
	// ----------------------------------------

	// Zero padding on top of the seed
	localparam int SeedPadW = `ORAM_BLK_W - `ORAM_IV_W - `ORAM_BID_W - `ORAM_CID_W;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	// Host command, one per bucket
	typedef struct packed {
		logic [`ORAM_IV_W-1:0]  iv;
		logic [`ORAM_BID_W-1:0] bucketId;
	} cmdT;

	// One seed per chunk, MSB first
	typedef struct packed {
		logic [SeedPadW-1:0]    pad;
		logic [`ORAM_IV_W-1:0]  iv;
		logic [`ORAM_BID_W-1:0] bucketId;
		logic [`ORAM_CID_W-1:0] chunkId;
	} seedT;

	// Keystream for one data beat
	typedef struct packed {
		logic [`ORAM_BLK_W-1:0] mask;
	} maskT;

endpackage

/* oramCrypto_params.svh */
/*
 * Bucket encryption widths, queue depths,
 * round count and cipher key constants
 */
`ifndef ORAM_CRYPTO_PARAMS_SVH
`define ORAM_CRYPTO_PARAMS_SVH

// Seed field widths
`define ORAM_IV_W 32
`define ORAM_BID_W 16
`define ORAM_CID_W 3
`define ORAM_BKT_CHUNKS 8

// Cipher block, same as one data beat
`define ORAM_BLK_W 64
`define ORAM_ROUNDS 4
`define ORAM_ROT 13

// Round keys, one per round
`define ORAM_KEY0 64'h3C6E_F372_A54F_F53A
`define ORAM_KEY1 64'h510E_527F_9B05_688C
`define ORAM_KEY2 64'h1F83_D9AB_5BE0_CD19
`define ORAM_KEY3 64'hCBBB_9D5D_629A_292A
`define ORAM_RCONST 64'h9E37_79B9_7F4A_7C15

// Queue depths
`define ORAM_CMD_DEPTH 4
`define ORAM_MASK_DEPTH 8

`endif
